// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = filter_engine_tb
FILELIST = src.f
OBJ_DIR  = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: include/filter_engine_config.svh
`ifndef FILTER_ENGINE_CONFIG_SVH
`define FILTER_ENGINE_CONFIG_SVH

// ------------------------------------------------------------
// Engine packet geometry
// ------------------------------------------------------------

// Fields carried by one engine packet
`define FILTER_NUM_FIELDS 4

// Bits per field, unsigned
`define FILTER_FIELD_WIDTH 32

`endif

// File: src.f
+incdir+include
src/filter_engine_pkg.sv
src/filter_operand_if.sv
src/filter_result_if.sv
src/filter_operand_select.sv
src/filter_cond_alu.sv
src/filter_result_reduce.sv
src/filter_engine_top.sv
verification/filter_engine_tb.sv

// File: src/filter_cond_alu.sv
`timescale 1ns/100ps
`default_nettype none

`include "filter_engine_config.svh"

module filter_cond_alu import filter_engine_pkg::*; (
  input  logic              ap_clk,
  input  logic              arst_n,
  filter_operand_if.sink    operand_in,
  filter_result_if.source   result_out
);

  localparam int N = `FILTER_NUM_FIELDS;

  engine_packet_t ops;
  engine_packet_t org;
  // Neighbour of each operand, wrapping at the top field
  engine_packet_t ops_rot;

  engine_packet_t result_next;
  field_mask_t    cond_next;

  // Ternary swap requests
  logic           swap_lead;
  logic           swap_ends;

  assign ops = operand_in.ops_packet;
  assign org = operand_in.org_packet;

  always_comb begin
    for (int i = 0; i < N; i++) begin
      ops_rot[i] = ops[(i + 1) % N];
    end
  end

  // ------------------------------------------------------------
  // Operation decode
  // ------------------------------------------------------------

  always_comb begin
    result_next = org;
    cond_next   = '1;
    swap_lead   = 1'b0;
    swap_ends   = 1'b0;

    case (operand_in.filter_op)
      FILTER_NOP: begin
        result_next = ops;
      end
      FILTER_GT: begin
        for (int i = 0; i < N; i++) begin
          cond_next[i] = ops[i] > ops_rot[i];
        end
      end
      FILTER_LT: begin
        for (int i = 0; i < N; i++) begin
          cond_next[i] = ops[i] < ops_rot[i];
        end
      end
      FILTER_EQ: begin
        for (int i = 0; i < N; i++) begin
          cond_next[i] = ops[i] == ops_rot[i];
        end
      end
      FILTER_NOT_EQ: begin
        for (int i = 0; i < N; i++) begin
          cond_next[i] = ops[i] != ops_rot[i];
        end
      end
      FILTER_GT_TERN: begin
        result_next = ops;
        swap_lead   = !(ops[0] > ops[1]);
      end
      FILTER_LT_TERN: begin
        result_next = ops;
        swap_lead   = !(ops[0] < ops[1]);
      end
      FILTER_EQ_TERN: begin
        result_next = ops;
        swap_ends   = ops[0] == ops[1];
      end
      FILTER_NOT_EQ_TERN: begin
        result_next = ops;
        swap_ends   = ops[0] != ops[1];
      end
      // Undefined codes fall back to the original packet
      default: begin
        result_next = org;
      end
    endcase

    if (swap_lead) begin
      result_next[0] = ops[1];
      result_next[1] = ops[0];
    end
    if (swap_ends) begin
      result_next[0]   = ops[N-1];
      result_next[N-1] = ops[0];
    end
  end

  // ------------------------------------------------------------
  // Stage register
  // ------------------------------------------------------------

  always_ff @(posedge ap_clk or negedge arst_n) begin
    if (!arst_n) begin
      result_out.valid <= 1'b0;
    end else begin
      result_out.valid <= operand_in.valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    result_out.result_packet <= result_next;
    result_out.cond_bits     <= cond_next;
    result_out.filter_mask   <= operand_in.filter_mask;
  end

endmodule : filter_cond_alu

`default_nettype wire

// File: src/filter_engine_pkg.sv
`default_nettype none

`include "filter_engine_config.svh"

package filter_engine_pkg;

  // ------------------------------------------------------------
  // Packet types
  // ------------------------------------------------------------

  typedef logic [`FILTER_FIELD_WIDTH-1:0] field_t;

  // Field 0 sits in the least significant slot
  typedef field_t [`FILTER_NUM_FIELDS-1:0] engine_packet_t;

  // One bit per field: constant mask, filter mask, condition bits
  typedef logic [`FILTER_NUM_FIELDS-1:0] field_mask_t;

  // Row i picks the source field of operand i
  typedef field_mask_t [`FILTER_NUM_FIELDS-1:0] ops_mask_t;

  // ------------------------------------------------------------
  // Filter operations
  // ------------------------------------------------------------

  typedef logic [3:0] filter_op_t;

  localparam filter_op_t FILTER_NOP         = 4'd0;
  localparam filter_op_t FILTER_GT          = 4'd1;
  localparam filter_op_t FILTER_LT          = 4'd2;
  localparam filter_op_t FILTER_EQ          = 4'd3;
  localparam filter_op_t FILTER_NOT_EQ      = 4'd4;
  // Ternary forms reorder leading fields instead of comparing
  localparam filter_op_t FILTER_GT_TERN     = 4'd5;
  localparam filter_op_t FILTER_LT_TERN     = 4'd6;
  localparam filter_op_t FILTER_EQ_TERN     = 4'd7;
  localparam filter_op_t FILTER_NOT_EQ_TERN = 4'd8;

endpackage : filter_engine_pkg

`default_nettype wire

// File: src/filter_engine_top.sv
`timescale 1ns/100ps
`default_nettype none

module filter_engine_top import filter_engine_pkg::*; (
  input  logic           ap_clk,
  input  logic           arst_n,
  input  logic           in_valid,
  input  engine_packet_t in_packet,
  input  field_mask_t    const_mask,
  input  field_t         const_value,
  input  ops_mask_t      ops_mask,
  input  filter_op_t     filter_op,
  input  field_mask_t    filter_mask,
  output logic           out_valid,
  output engine_packet_t out_packet,
  output logic           out_keep
);

  // Stage boundaries
  filter_operand_if operand_bus ();
  filter_result_if  result_bus ();

  // ------------------------------------------------------------
  // Three-stage pipe: select, ALU, reduce
  // ------------------------------------------------------------

  filter_operand_select i_operand_select (
    .ap_clk      (ap_clk),
    .arst_n      (arst_n),
    .in_valid    (in_valid),
    .in_packet   (in_packet),
    .const_mask  (const_mask),
    .const_value (const_value),
    .ops_mask    (ops_mask),
    .filter_op   (filter_op),
    .filter_mask (filter_mask),
    .operand_out (operand_bus.source)
  );

  filter_cond_alu i_cond_alu (
    .ap_clk     (ap_clk),
    .arst_n     (arst_n),
    .operand_in (operand_bus.sink),
    .result_out (result_bus.source)
  );

  filter_result_reduce i_result_reduce (
    .ap_clk     (ap_clk),
    .arst_n     (arst_n),
    .result_in  (result_bus.sink),
    .out_valid  (out_valid),
    .out_packet (out_packet),
    .out_keep   (out_keep)
  );

endmodule : filter_engine_top

`default_nettype wire

// File: src/filter_operand_if.sv
`timescale 1ns/100ps
`default_nettype none

// Stage 1 to ALU boundary
interface filter_operand_if import filter_engine_pkg::*; ();

  logic           valid;
  engine_packet_t ops_packet;
  // Input packet after routing, before constants
  engine_packet_t org_packet;
  filter_op_t     filter_op;
  field_mask_t    filter_mask;

  modport source (
    output valid,
    output ops_packet,
    output org_packet,
    output filter_op,
    output filter_mask
  );

  modport sink (
    input valid,
    input ops_packet,
    input org_packet,
    input filter_op,
    input filter_mask
  );

endinterface : filter_operand_if

`default_nettype wire

// File: src/filter_operand_select.sv
`timescale 1ns/100ps
`default_nettype none

`include "filter_engine_config.svh"

module filter_operand_select import filter_engine_pkg::*; (
  input  logic                    ap_clk,
  input  logic                    arst_n,
  input  logic                    in_valid,
  input  engine_packet_t          in_packet,
  input  field_mask_t             const_mask,
  input  field_t                  const_value,
  input  ops_mask_t               ops_mask,
  input  filter_op_t              filter_op,
  input  field_mask_t             filter_mask,
  filter_operand_if.source        operand_out
);

  localparam int N = `FILTER_NUM_FIELDS;

  // Field picked by each ops_mask row, zero when the row is empty
  engine_packet_t routed;
  engine_packet_t ops_next;
  engine_packet_t org_next;

  // ------------------------------------------------------------
  // Operand and original-packet selection
  // ------------------------------------------------------------

  always_comb begin
    for (int i = 0; i < N; i++) begin
      routed[i] = '0;
      // Later hits overwrite earlier ones, so the highest set bit wins
      for (int j = 0; j < N; j++) begin
        if (ops_mask[i][j]) begin
          routed[i] = in_packet[j];
        end
      end

      if (|ops_mask[i]) begin
        org_next[i] = routed[i];
      end else begin
        org_next[i] = in_packet[i];
      end

      // Constant overrides routing
      if (const_mask[i]) begin
        ops_next[i] = const_value;
      end else begin
        ops_next[i] = routed[i];
      end
    end
  end

  // ------------------------------------------------------------
  // Stage register
  // ------------------------------------------------------------

  always_ff @(posedge ap_clk or negedge arst_n) begin
    if (!arst_n) begin
      operand_out.valid <= 1'b0;
    end else begin
      operand_out.valid <= in_valid;
    end
  end

  // Configuration rides along with its packet
  always_ff @(posedge ap_clk) begin
    operand_out.ops_packet  <= ops_next;
    operand_out.org_packet  <= org_next;
    operand_out.filter_op   <= filter_op;
    operand_out.filter_mask <= filter_mask;
  end

endmodule : filter_operand_select

`default_nettype wire

// File: src/filter_result_if.sv
`timescale 1ns/100ps
`default_nettype none

// ALU to reducer boundary
interface filter_result_if import filter_engine_pkg::*; ();

  logic           valid;
  engine_packet_t result_packet;
  // One compare outcome per field, unmasked
  field_mask_t    cond_bits;
  field_mask_t    filter_mask;

  modport source (
    output valid,
    output result_packet,
    output cond_bits,
    output filter_mask
  );

  modport sink (
    input valid,
    input result_packet,
    input cond_bits,
    input filter_mask
  );

endinterface : filter_result_if

`default_nettype wire

// File: src/filter_result_reduce.sv
`timescale 1ns/100ps
`default_nettype none

module filter_result_reduce import filter_engine_pkg::*; (
  input  logic              ap_clk,
  input  logic              arst_n,
  filter_result_if.sink     result_in,
  output logic              out_valid,
  output engine_packet_t    out_packet,
  output logic              out_keep
);

  // A cleared filter-mask bit forces its condition to pass
  field_mask_t pass_bits;
  logic        keep_next;

  assign pass_bits = result_in.cond_bits | ~result_in.filter_mask;
  assign keep_next = &pass_bits;

  // ------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------

  always_ff @(posedge ap_clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= result_in.valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    out_packet <= result_in.result_packet;
    out_keep   <= keep_next;
  end

endmodule : filter_result_reduce

`default_nettype wire

// File: verification/filter_engine_tb.sv
`timescale 1ns/100ps
`default_nettype none

module filter_engine_tb import filter_engine_pkg::*; ();

  localparam int N = $bits(field_mask_t);
  localparam int LATENCY = 3;
  // Row i routes field i
  localparam ops_mask_t IDENT = {4'b1000, 4'b0100, 4'b0010, 4'b0001};

  logic           ap_clk;
  logic           arst_n;
  logic           in_valid;
  engine_packet_t in_packet;
  field_mask_t    const_mask;
  field_t         const_value;
  ops_mask_t      ops_mask;
  filter_op_t     filter_op;
  field_mask_t    filter_mask;
  logic           out_valid;
  engine_packet_t out_packet;
  logic           out_keep;

  // Expected outputs in issue order, stamped with the issue cycle
  int             cyc = 0;
  int             exp_issue[$];
  engine_packet_t exp_packet[$];
  logic           exp_keep[$];

  filter_engine_top i_dut (.*);

  initial begin
    ap_clk = 1'b0;
    forever #2 ap_clk = ~ap_clk;
  end

  always @(posedge ap_clk) cyc <= cyc + 1;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------

  function automatic void model(input engine_packet_t pkt, input field_mask_t cmask,
                                input field_t cval, input ops_mask_t omask,
                                input filter_op_t op, input field_mask_t fmask,
                                output engine_packet_t res, output logic keep);
    engine_packet_t o;
    engine_packet_t g;
    field_mask_t    c;
    field_t         nb;
    int             src;
    for (int i = 0; i < N; i++) begin
      src = -1;
      // Scan from the top so the highest set bit is found first
      for (int j = N - 1; j >= 0; j--) begin
        if (src < 0 && omask[i][j]) src = j;
      end
      g[i] = (src >= 0) ? pkt[src] : pkt[i];
      o[i] = cmask[i] ? cval : ((src >= 0) ? pkt[src] : '0);
    end
    c = '1;
    res = o;
    case (op)
      FILTER_GT, FILTER_LT, FILTER_EQ, FILTER_NOT_EQ: begin
        res = g;
        for (int i = 0; i < N; i++) begin
          nb = o[(i + 1) % N];
          case (op)
            FILTER_GT: c[i] = o[i] > nb;
            FILTER_LT: c[i] = o[i] < nb;
            FILTER_EQ: c[i] = o[i] == nb;
            default:   c[i] = o[i] != nb;
          endcase
        end
      end
      FILTER_NOP: res = o;
      FILTER_GT_TERN, FILTER_LT_TERN: begin
        if ((op == FILTER_GT_TERN) ? !(o[0] > o[1]) : !(o[0] < o[1])) begin
          res[0] = o[1];
          res[1] = o[0];
        end
      end
      FILTER_EQ_TERN, FILTER_NOT_EQ_TERN: begin
        if ((o[0] == o[1]) == (op == FILTER_EQ_TERN)) begin
          res[0]   = o[N-1];
          res[N-1] = o[0];
        end
      end
      default: res = g;
    endcase
    keep = &(c | ~fmask);
  endfunction

  // ------------------------------------------------------------
  // Drivers and output monitor
  // ------------------------------------------------------------

  task automatic send(input engine_packet_t pkt, input field_mask_t cmask, input field_t cval,
                      input ops_mask_t omask, input filter_op_t op, input field_mask_t fmask);
    engine_packet_t res;
    logic           keep;
    @(negedge ap_clk);
    in_valid    = 1'b1;
    in_packet   = pkt;
    const_mask  = cmask;
    const_value = cval;
    ops_mask    = omask;
    filter_op   = op;
    filter_mask = fmask;
    model(pkt, cmask, cval, omask, op, fmask, res, keep);
    exp_packet.push_back(res);
    exp_keep.push_back(keep);
    exp_issue.push_back(cyc);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge ap_clk);
      in_valid = 1'b0;
    end
  endtask

  task automatic drain();
    int waited = 0;
    idle(1);
    while (exp_issue.size() > 0 && waited < 4 * LATENCY) begin
      @(negedge ap_clk);
      waited++;
    end
    if (exp_issue.size() > 0) begin
      abort_run($sformatf("Timeout at %0t: %0d packets never left the pipe",
                          $time, exp_issue.size()));
    end
  endtask

  always @(negedge ap_clk) begin
    if (!arst_n) begin
      assert (!out_valid) else abort_run($sformatf("[FAIL] %0t: out_valid in reset", $time));
    end else if (out_valid) begin
      assert (exp_issue.size() > 0)
        else abort_run($sformatf("[FAIL] %0t: out_valid with nothing in flight", $time));
      assert (cyc == exp_issue[0] + LATENCY)
        else abort_run($sformatf("[FAIL] %0t: latency %0d", $time, cyc - exp_issue[0]));
      assert (out_packet == exp_packet[0])
        else abort_run($sformatf("[FAIL] %0t: packet %h, expected %h",
                                 $time, out_packet, exp_packet[0]));
      assert (out_keep == exp_keep[0])
        else abort_run($sformatf("[FAIL] %0t: keep %b, expected %b",
                                 $time, out_keep, exp_keep[0]));
      exp_issue.delete(0);
      exp_packet.delete(0);
      exp_keep.delete(0);
    end else if (exp_issue.size() > 0) begin
      assert (cyc < exp_issue[0] + LATENCY)
        else abort_run($sformatf("[FAIL] %0t: expected packet did not appear", $time));
    end
  end

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------

  task automatic test_idle_after_reset();
    repeat (10) begin
      @(negedge ap_clk);
      assert (!out_valid)
        else abort_run($sformatf("[FAIL] %0t: out_valid high while idle", $time));
    end
  endtask

  task automatic test_operand_select();
    engine_packet_t pkt = {32'd40, 32'd30, 32'd20, 32'd10};
    send(pkt, 4'b0000, '0, IDENT, FILTER_NOP, '1);
    send(pkt, 4'b1111, 32'hdead_beef, IDENT, FILTER_NOP, '1);
    send(pkt, 4'b0000, '0, '0, FILTER_NOP, '1);
    // Multi-bit rows, one constant, one empty row
    send(pkt, 4'b0010, 32'd7, {4'b0001, 4'b0000, 4'b1000, 4'b0110}, FILTER_NOP, '1);
    drain();
  endtask

  task automatic test_compare();
    field_mask_t    masks[4] = '{4'b0000, 4'b1000, 4'b0011, 4'b1111};
    engine_packet_t pkts[2] = '{{32'd5, 32'd5, 32'd9, 32'd3}, {32'd7, 32'd1, 32'd1, 32'd8}};
    for (int k = 1; k <= 4; k++) begin
      foreach (masks[m]) begin
        send(pkts[m % 2], '0, '0, IDENT, 4'(k), masks[m]);
        // Constant operand, so the original packet differs from the operands
        send(pkts[(m + 1) % 2], 4'b0010, 32'd6, IDENT, 4'(k), masks[m]);
      end
    end
    drain();
  endtask

  task automatic test_ternary();
    // Lead fields less, equal and greater
    engine_packet_t pkts[3] = '{{32'd4, 32'd3, 32'd9, 32'd2}, {32'd4, 32'd3, 32'd2, 32'd2},
                                {32'd4, 32'd3, 32'd1, 32'd7}};
    for (int k = 5; k <= 8; k++) begin
      foreach (pkts[p]) send(pkts[p], '0, '0, IDENT, 4'(k), '1);
    end
    drain();
  endtask

  task automatic test_undefined_op();
    for (int k = 9; k <= 15; k++) begin
      send({32'd4, 32'd3, 32'd2, 32'd1}, 4'b0101, 32'd9, {4'b0001, 4'b0000, 4'b1000, 4'b0110},
           4'(k), '1);
    end
    drain();
  endtask

  function automatic field_t rand_field();
    // Small values half the time so compares hit equality
    return ($urandom % 2 == 0) ? $urandom % 4 : $urandom;
  endfunction

  task automatic test_stream();
    engine_packet_t pkt;
    for (int k = 0; k < 200; k++) begin
      foreach (pkt[f]) pkt[f] = rand_field();
      send(pkt, 4'($urandom & $urandom), rand_field(), 16'($urandom), 4'($urandom % 10),
           4'($urandom));
      if ($urandom % 4 == 0) idle(1 + $urandom % 3);
    end
    drain();
  endtask

  initial begin
    void'($urandom(43));
    arst_n      = 1'b0;
    // Valid held high, only the reset keeps the pipe empty
    in_valid    = 1'b1;
    in_packet   = '0;
    const_mask  = '0;
    const_value = '0;
    ops_mask    = '0;
    filter_op   = FILTER_NOP;
    filter_mask = '0;
    repeat (8) @(posedge ap_clk);
    @(negedge ap_clk);
    arst_n   = 1'b1;
    in_valid = 1'b0;
    test_idle_after_reset();
    test_operand_select();
    test_compare();
    test_ternary();
    test_undefined_op();
    test_stream();
    $display("all tests passed");
    $finish;
  end

endmodule : filter_engine_tb

`default_nettype wire
